//--- pers_pkg.sv
package pers_pkg;

   // ********************
   // Dispatch word types
   // ********************
   typedef logic [63:0] data_t;
   typedef logic [31:0] inst_t;
   typedef logic [17:0] aeg_idx_t;
   typedef logic [4:0]  caep_t;
   typedef logic [15:0] exc_t;

   // Opcode field, instruction bits 31:28
   typedef enum logic [3:0] {
      OP_CAEP   = 4'd1,
      OP_AEG_WR = 4'd2,
      OP_AEG_RD = 4'd3
   } op_e;

   // Implemented custom instructions
   localparam caep_t CAEP_HELLO  = 5'd0;
   localparam caep_t CAEP_LAUNCH = 5'd1;
   localparam caep_t CAEP_NOP    = 5'd2;

   // Exception vector bit positions
   localparam int EXC_UNIMPL  = 0;
   localparam int EXC_BAD_IDX = 1;

   // ********************
   // Engine commands
   // ********************
   localparam logic [2:0] CMD_CODE_RESET = 3'd1;
   localparam logic [4:0] CMD_ARG_RESET  = 5'd16;

   // Code in bits 2:0, argument in bits 7:3
   localparam data_t RESET_CMD = {56'd0, CMD_ARG_RESET, CMD_CODE_RESET};

endpackage

//--- inst_decode.sv
`timescale 1ns/1ps

module inst_decode #(
   parameter int NUM_AEG = 2
) (
   input  logic                inst_vld_i,
   input  pers_pkg::inst_t     inst_i,
   output logic                aeg_wr_o,
   output logic                aeg_rd_o,
   output pers_pkg::aeg_idx_t  aeg_idx_o,
   output logic                idx_err_o,
   output logic                unimpl_o,
   output logic                launch_o
);
   import pers_pkg::*;

   localparam aeg_idx_t AEG_LIMIT = aeg_idx_t'(NUM_AEG);

   op_e   op;
   caep_t caep;
   logic  idx_ok;

   // Instruction fields
   assign op        = op_e'(inst_i[31:28]);
   assign caep      = inst_i[22:18];
   assign aeg_idx_o = inst_i[17:0];
   assign idx_ok    = aeg_idx_o < AEG_LIMIT;

   always_comb begin
      aeg_wr_o  = 1'b0;
      aeg_rd_o  = 1'b0;
      idx_err_o = 1'b0;
      unimpl_o  = 1'b0;
      launch_o  = 1'b0;
      if (inst_vld_i) begin
         case (op)
            OP_AEG_WR: begin
               aeg_wr_o  = idx_ok;
               idx_err_o = !idx_ok;
            end
            OP_AEG_RD: begin
               aeg_rd_o  = idx_ok;
               idx_err_o = !idx_ok;
            end
            OP_CAEP: begin
               // Hello and nop complete in the decode cycle
               if (caep == CAEP_LAUNCH) begin
                  launch_o = 1'b1;
               end else if (caep != CAEP_HELLO && caep != CAEP_NOP) begin
                  unimpl_o = 1'b1;
               end
            end
            default: unimpl_o = 1'b1;
         endcase
      end
   end

endmodule

//--- aeg_file.sv
`timescale 1ns/1ps

module aeg_file #(
   parameter int NUM_AEG = 2
) (
   input  logic                clk,
   input  logic                reset_per,
   input  logic                aeg_wr_i,
   input  logic                aeg_rd_i,
   input  pers_pkg::aeg_idx_t  aeg_idx_i,
   input  pers_pkg::data_t     data_i,
   input  logic                idx_err_i,
   input  logic                unimpl_i,
   output logic                ret_vld_o,
   output pers_pkg::data_t     ret_data_o,
   output pers_pkg::exc_t      exception_o,
   output pers_pkg::data_t     aeg0_o
);
   import pers_pkg::*;

   data_t aeg_q [NUM_AEG];
   data_t rd_data;
   exc_t  exc_d;

   // ********************
   // Register bank
   // ********************
   always_ff @(posedge clk) begin
      if (reset_per) begin
         for (int i = 0; i < NUM_AEG; i++) begin
            aeg_q[i] <= '0;
         end
      end else begin
         for (int i = 0; i < NUM_AEG; i++) begin
            if (aeg_wr_i && aeg_idx_i == aeg_idx_t'(i)) begin
               aeg_q[i] <= data_i;
            end
         end
      end
   end

   always_comb begin
      rd_data = '0;
      for (int i = 0; i < NUM_AEG; i++) begin
         if (aeg_idx_i == aeg_idx_t'(i)) begin
            rd_data = aeg_q[i];
         end
      end
   end

   always_comb begin
      exc_d              = '0;
      exc_d[EXC_UNIMPL]  = unimpl_i;
      exc_d[EXC_BAD_IDX] = idx_err_i;
   end

   // Return path, one cycle after decode
   always_ff @(posedge clk) begin
      if (reset_per) begin
         ret_vld_o   <= 1'b0;
         exception_o <= '0;
      end else begin
         ret_vld_o   <= aeg_rd_i;
         exception_o <= exc_d;
      end
   end

   always_ff @(posedge clk) begin
      if (aeg_rd_i) begin
         ret_data_o <= rd_data;
      end
   end

   assign aeg0_o = aeg_q[0];

endmodule

//--- busy_timer.sv
`timescale 1ns/1ps

module busy_timer #(
   parameter int MIN_BUSY_CYCLES = 32,
   parameter int WATCHDOG_BITS   = 22
) (
   input  logic clk,
   input  logic reset_per,
   input  logic hold_start_i,
   input  logic busy_i,
   output logic hold_active_o,
   output logic watchdog_expired_o
);

   localparam int HOLD_W = $clog2(MIN_BUSY_CYCLES + 1);

   logic [HOLD_W-1:0]      hold_cnt;
   logic [WATCHDOG_BITS:0] wd_cnt;

   // ********************
   // Minimum hold
   // ********************
   always_ff @(posedge clk) begin
      if (reset_per || watchdog_expired_o) begin
         hold_cnt <= '0;
      end else if (hold_start_i) begin
         hold_cnt <= HOLD_W'(MIN_BUSY_CYCLES);
      end else if (hold_cnt != '0) begin
         hold_cnt <= hold_cnt - 1'b1;
      end
   end

   assign hold_active_o = hold_cnt != '0;

   // Watchdog counts continuous busy cycles
   always_ff @(posedge clk) begin
      if (reset_per || watchdog_expired_o || !busy_i) begin
         wd_cnt <= '0;
      end else begin
         wd_cnt <= wd_cnt + 1'b1;
      end
   end

   // Top bit set after 2**WATCHDOG_BITS busy cycles
   assign watchdog_expired_o = wd_cnt[WATCHDOG_BITS];

endmodule

//--- launch_ctrl.sv
`timescale 1ns/1ps

module launch_ctrl (
   input  logic             clk,
   input  logic             reset_per,
   input  logic             launch_i,
   input  pers_pkg::data_t  aeg0_i,
   input  logic             engine_busy_i,
   input  logic             hold_active_i,
   input  logic             watchdog_expired_i,
   output logic             hold_start_o,
   output logic             busy_o,
   output logic             cmd_vld_o,
   output pers_pkg::data_t  cmd_o,
   output logic             idle_o,
   output logic             stall_o
);
   import pers_pkg::*;

   typedef enum logic [1:0] {
      ST_RESET_CMD,
      ST_IDLE,
      ST_SEND,
      ST_HOLD
   } state_e;

   state_e state_q;
   state_e state_d;
   data_t  payload_q;

   // ********************
   // Command FSM
   // ********************
   always_comb begin
      state_d = state_q;
      case (state_q)
         ST_RESET_CMD: state_d = ST_IDLE;
         ST_IDLE:      if (launch_i) state_d = ST_SEND;
         ST_SEND:      state_d = ST_HOLD;
         ST_HOLD:      if (!hold_active_i) state_d = ST_IDLE;
         default:      state_d = ST_RESET_CMD;
      endcase
      // Hung engine gets a fresh reset command
      if (watchdog_expired_i) begin
         state_d = ST_RESET_CMD;
      end
   end

   always_ff @(posedge clk) begin
      if (reset_per) begin
         state_q <= ST_RESET_CMD;
      end else begin
         state_q <= state_d;
      end
   end

   // Launch payload, captured at the launch edge
   always_ff @(posedge clk) begin
      if (state_q == ST_IDLE && launch_i) begin
         payload_q <= aeg0_i;
      end
   end

   assign cmd_vld_o    = state_q == ST_RESET_CMD || state_q == ST_SEND;
   assign cmd_o        = (state_q == ST_SEND) ? payload_q : RESET_CMD;
   assign hold_start_o = state_q == ST_SEND;

   // Busy seen by the watchdog, stall adds the launch in decode
   assign busy_o  = state_q != ST_IDLE || engine_busy_i;
   assign stall_o = busy_o || launch_i;
   assign idle_o  = !stall_o;

endmodule

//--- cae_pers_top.sv
`timescale 1ns/1ps

module cae_pers_top #(
   parameter int NUM_AEG         = 2,
   parameter int MIN_BUSY_CYCLES = 32,
   parameter int WATCHDOG_BITS   = 22
) (
   input  logic                clk,
   input  logic                reset_per,
   // Dispatch
   input  logic                inst_vld_i,
   input  pers_pkg::inst_t     inst_i,
   input  pers_pkg::data_t     data_i,
   output pers_pkg::aeg_idx_t  aeg_cnt_o,
   output logic                ret_vld_o,
   output pers_pkg::data_t     ret_data_o,
   output pers_pkg::exc_t      exception_o,
   output logic                idle_o,
   output logic                stall_o,
   // Engine
   output logic                cmd_vld_o,
   output pers_pkg::data_t     cmd_o,
   input  logic                engine_busy_i
);
   import pers_pkg::*;

   logic     aeg_wr;
   logic     aeg_rd;
   aeg_idx_t aeg_idx;
   logic     idx_err;
   logic     unimpl;
   logic     launch;
   data_t    aeg0;
   logic     hold_start;
   logic     busy;
   logic     hold_active;
   logic     watchdog_expired;

   assign aeg_cnt_o = aeg_idx_t'(NUM_AEG);

   // ********************
   // Decode and registers
   // ********************
   inst_decode #(
      .NUM_AEG (NUM_AEG)
   ) u_inst_decode (
      .inst_vld_i (inst_vld_i),
      .inst_i     (inst_i),
      .aeg_wr_o   (aeg_wr),
      .aeg_rd_o   (aeg_rd),
      .aeg_idx_o  (aeg_idx),
      .idx_err_o  (idx_err),
      .unimpl_o   (unimpl),
      .launch_o   (launch)
   );

   aeg_file #(
      .NUM_AEG (NUM_AEG)
   ) u_aeg_file (
      .clk         (clk),
      .reset_per   (reset_per),
      .aeg_wr_i    (aeg_wr),
      .aeg_rd_i    (aeg_rd),
      .aeg_idx_i   (aeg_idx),
      .data_i      (data_i),
      .idx_err_i   (idx_err),
      .unimpl_i    (unimpl),
      .ret_vld_o   (ret_vld_o),
      .ret_data_o  (ret_data_o),
      .exception_o (exception_o),
      .aeg0_o      (aeg0)
   );

   // ********************
   // Engine control
   // ********************
   busy_timer #(
      .MIN_BUSY_CYCLES (MIN_BUSY_CYCLES),
      .WATCHDOG_BITS   (WATCHDOG_BITS)
   ) u_busy_timer (
      .clk                (clk),
      .reset_per          (reset_per),
      .hold_start_i       (hold_start),
      .busy_i             (busy),
      .hold_active_o      (hold_active),
      .watchdog_expired_o (watchdog_expired)
   );

   launch_ctrl u_launch_ctrl (
      .clk                (clk),
      .reset_per          (reset_per),
      .launch_i           (launch),
      .aeg0_i             (aeg0),
      .engine_busy_i      (engine_busy_i),
      .hold_active_i      (hold_active),
      .watchdog_expired_i (watchdog_expired),
      .hold_start_o       (hold_start),
      .busy_o             (busy),
      .cmd_vld_o          (cmd_vld_o),
      .cmd_o              (cmd_o),
      .idle_o             (idle_o),
      .stall_o            (stall_o)
   );

endmodule

//--- cae_pers_props.sv
`timescale 1ns/1ps

module cae_pers_props (
   input logic clk,
   input logic reset_per,
   input logic launch_i,
   input logic busy_o,
   input logic cmd_vld_o
);

   // Commands are single-cycle pulses
   assert property (@(posedge clk) disable iff (reset_per)
                    cmd_vld_o |=> !cmd_vld_o)
      else $error("cmd_vld_o held for two cycles");

   // Accepted launch issues its command next cycle
   assert property (@(posedge clk) disable iff (reset_per)
                    launch_i |=> cmd_vld_o)
      else $error("launch not followed by a command");

   // Host must respect back-pressure
   assert property (@(posedge clk) disable iff (reset_per)
                    !(launch_i && busy_o))
      else $error("launch dispatched while stalled");

endmodule

bind launch_ctrl cae_pers_props u_cae_pers_props (
   .clk       (clk),
   .reset_per (reset_per),
   .launch_i  (launch_i),
   .busy_o    (busy_o),
   .cmd_vld_o (cmd_vld_o)
);

//--- tb_cae_pers.sv
`timescale 1ns/1ps

module tb_cae_pers;
   import pers_pkg::*;

   localparam int NUM_AEG         = 2;
   localparam int MIN_BUSY_CYCLES = 32;
   localparam int WATCHDOG_BITS   = 6;
   localparam int WDOG_LIMIT      = 2**WATCHDOG_BITS + MIN_BUSY_CYCLES + 4;

   // Engine reset word, code 1 in bits 2:0 and 16 in bits 7:3
   localparam data_t EXP_RESET_CMD = 64'h0000_0000_0000_0081;

   logic     clk;
   logic     reset_per;
   logic     inst_vld_i;
   inst_t    inst_i;
   data_t    data_i;
   logic     engine_busy_i;
   aeg_idx_t aeg_cnt_o;
   logic     ret_vld_o;
   data_t    ret_data_o;
   exc_t     exception_o;
   logic     idle_o;
   logic     stall_o;
   logic     cmd_vld_o;
   data_t    cmd_o;

   string    t_name [$];
   string    t_op [$];
   inst_t    t_inst [$];
   data_t    t_data [$];
   data_t    t_exp_data [$];
   exc_t     t_exp_exc [$];

   int          cycles = 0;
   int          cycle_limit = 0;
   logic [31:0] rng = 32'd32485;

   cae_pers_top #(
      .NUM_AEG         (NUM_AEG),
      .MIN_BUSY_CYCLES (MIN_BUSY_CYCLES),
      .WATCHDOG_BITS   (WATCHDOG_BITS)
   ) u_cae_pers_top (
      .clk           (clk),
      .reset_per     (reset_per),
      .inst_vld_i    (inst_vld_i),
      .inst_i        (inst_i),
      .data_i        (data_i),
      .aeg_cnt_o     (aeg_cnt_o),
      .ret_vld_o     (ret_vld_o),
      .ret_data_o    (ret_data_o),
      .exception_o   (exception_o),
      .idle_o        (idle_o),
      .stall_o       (stall_o),
      .cmd_vld_o     (cmd_vld_o),
      .cmd_o         (cmd_o),
      .engine_busy_i (engine_busy_i)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // ********************
   // Helpers
   // ********************
   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("Simulation failed");
      $fatal(1);
   endtask

   task automatic check_data(input string name, input data_t exp, input data_t act);
      if (exp !== act) begin
         fail_run($sformatf("Mismatch %s expected %h actual %h", name, exp, act));
      end
   endtask

   task automatic check_exc(input string name, input exc_t exp, input exc_t act);
      if (exp !== act) begin
         fail_run($sformatf("Mismatch %s expected %h actual %h", name, exp, act));
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (exp !== act) begin
         fail_run($sformatf("Mismatch %s expected %b actual %b", name, exp, act));
      end
   endtask

   // Sample point one step after the edge
   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic wait_idle(input string name, input int limit);
      int n;
      n = 0;
      while (!idle_o) begin
         next_cycle();
         n++;
         if (n > limit) begin
            fail_run($sformatf("%s: design never returned to idle", name));
         end
      end
   endtask

   // Drives one instruction and returns just after the sampling edge
   task automatic dispatch(input string name, input inst_t inst, input data_t data,
                           input logic exp_stall);
      @(posedge clk);
      inst_vld_i <= 1'b1;
      inst_i     <= inst;
      data_i     <= data;
      #1;
      check_bit({name, "_decode_stall"}, exp_stall, stall_o);
      @(posedge clk);
      inst_vld_i <= 1'b0;
      #1;
   endtask

   task automatic read_tests();
      int    fd;
      int    n;
      string line;
      string name;
      string op;
      inst_t inst;
      data_t data;
      data_t exp_data;
      exc_t  exp_exc;
      fd = $fopen("cae_pers_tests.txt", "r");
      if (fd == 0) begin
         fail_run("Cannot open cae_pers_tests.txt");
      end
      while (!$feof(fd)) begin
         line = "";
         void'($fgets(line, fd));
         if (line.len() > 1 && line[0] != "#") begin
            n = $sscanf(line, "%s %s %h %h %h %h", name, op, inst, data, exp_data, exp_exc);
            if (n != 6) begin
               fail_run({"Malformed test line: ", line});
            end
            t_name.push_back(name);
            t_op.push_back(op);
            t_inst.push_back(inst);
            t_data.push_back(data);
            t_exp_data.push_back(exp_data);
            t_exp_exc.push_back(exp_exc);
         end
      end
      $fclose(fd);
   endtask

   task automatic run_launch(input int i);
      int stall_cycles;
      int gap;
      dispatch(t_name[i], t_inst[i], t_data[i], 1'b1);
      check_bit({t_name[i], "_cmd_vld"}, 1'b1, cmd_vld_o);
      check_data({t_name[i], "_cmd"}, t_exp_data[i], cmd_o);
      check_exc({t_name[i], "_exc"}, t_exp_exc[i], exception_o);
      stall_cycles = 0;
      while (stall_o) begin
         next_cycle();
         stall_cycles++;
         check_bit({t_name[i], "_cmd_quiet"}, 1'b0, cmd_vld_o);
         if (stall_cycles > MIN_BUSY_CYCLES + 8) begin
            fail_run($sformatf("%s: stall did not end after hold", t_name[i]));
         end
      end
      if (stall_cycles < MIN_BUSY_CYCLES) begin
         fail_run($sformatf("Mismatch %s_hold expected >= %0d actual %0d",
                            t_name[i], MIN_BUSY_CYCLES, stall_cycles));
      end
      // Engine stays quiet between launches
      rng = xorshift32(rng);
      gap = int'(rng % 8) + 1;
      repeat (gap) next_cycle();
      check_bit({t_name[i], "_idle"}, 1'b1, idle_o);
   endtask

   task automatic run_watchdog(input int i);
      int   n;
      logic seen;
      dispatch(t_name[i], t_inst[i], t_data[i], 1'b1);
      check_bit({t_name[i], "_cmd_vld"}, 1'b1, cmd_vld_o);
      check_data({t_name[i], "_cmd"}, t_exp_data[i], cmd_o);
      // Engine goes busy once the launch has been taken
      @(posedge clk);
      engine_busy_i <= 1'b1;
      #1;
      n    = 0;
      seen = 1'b0;
      while (!seen) begin
         next_cycle();
         n++;
         check_bit({t_name[i], "_busy_stall"}, 1'b1, stall_o);
         seen = cmd_vld_o && cmd_o == EXP_RESET_CMD;
         if (!seen && n > WDOG_LIMIT) begin
            fail_run($sformatf("%s: no reset command after watchdog", t_name[i]));
         end
      end
      @(posedge clk);
      engine_busy_i <= 1'b0;
      #1;
      wait_idle(t_name[i], MIN_BUSY_CYCLES + 8);
   endtask

   // ********************
   // Main sequence
   // ********************
   initial begin
      reset_per     = 1'b1;
      inst_vld_i    = 1'b0;
      inst_i        = '0;
      data_i        = '0;
      engine_busy_i = 1'b0;
      read_tests();
      cycle_limit = t_name.size() * (MIN_BUSY_CYCLES + 2**WATCHDOG_BITS + 20);
      repeat (5) @(posedge clk);
      reset_per <= 1'b0;
      #1;
      check_bit("reset_cmd_vld", 1'b1, cmd_vld_o);
      check_data("reset_cmd", EXP_RESET_CMD, cmd_o);
      next_cycle();
      check_bit("reset_idle", 1'b1, idle_o);
      check_data("aeg_cnt", 64'd2, data_t'(aeg_cnt_o));
      for (int i = 0; i < t_name.size(); i++) begin
         wait_idle(t_name[i], MIN_BUSY_CYCLES + 8);
         case (t_op[i])
            "wr", "rd", "ins": begin
               dispatch(t_name[i], t_inst[i], t_data[i], 1'b0);
               check_exc({t_name[i], "_exc"}, t_exp_exc[i], exception_o);
               check_bit({t_name[i], "_ret_vld"}, t_op[i] == "rd" && t_exp_exc[i] == '0,
                         ret_vld_o);
               if (ret_vld_o) begin
                  check_data(t_name[i], t_exp_data[i], ret_data_o);
               end
               check_bit({t_name[i], "_stall"}, 1'b0, stall_o);
            end
            "launch": run_launch(i);
            "wdog":   run_watchdog(i);
            default:  fail_run({"Unknown operation in test ", t_name[i]});
         endcase
      end
      $display("Simulation completed successfully");
      $finish;
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycle_limit > 0 && cycles > cycle_limit) begin
         fail_run("Timeout: the tests ran past their cycle limit");
      end
   end

endmodule

//--- cae_pers_tests.txt
# name op inst(hex) data(hex) exp_data(hex) exp_exc(hex)
# op: wr rd ins launch wdog
wr0 wr 20000000 1122334455667788 0 0
rd0 rd 30000000 0 1122334455667788 0
wr1 wr 20000001 a5a5a5a5deadbeef 0 0
rd1 rd 30000001 0 a5a5a5a5deadbeef 0
rd0_again rd 30000000 0 1122334455667788 0
wr_bad wr 20000002 ffffffffffffffff 0 2
rd_bad rd 30000002 0 0 2
rd_bad_big rd 3003ffff 0 0 2
rd0_kept rd 30000000 0 1122334455667788 0
rd1_kept rd 30000001 0 a5a5a5a5deadbeef 0
hello ins 10000000 0 0 0
nop ins 10080000 0 0 0
caep3 ins 100c0000 0 0 1
caep31 ins 107c0000 0 0 1
op0 ins 00000000 0 0 1
opf ins f0000000 0 0 1
launch1 launch 10040000 0 1122334455667788 0
wr0_new wr 20000000 0123456789abcdef 0 0
launch2 launch 10040000 0 0123456789abcdef 0
wdog wdog 10040000 0 0123456789abcdef 0
rd1_after rd 30000001 0 a5a5a5a5deadbeef 0

//--- verilog.f
pers_pkg.sv
inst_decode.sv
aeg_file.sv
busy_timer.sv
launch_ctrl.sv
cae_pers_top.sv
cae_pers_props.sv
tb_cae_pers.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator
verilator --binary --timing --assert -f verilog.f --top-module tb_cae_pers -o sim_cae_pers \
   && ./obj_dir/sim_cae_pers \
   || exit 1
